// File: rtl/cacheGeomPkg.sv
package cacheGeomPkg;

    ////////////////////////////////////////////////
    // Basic widths seen by the processor
    ////////////////////////////////////////////////

    typedef logic [31:0] wordT;     // One data word
    typedef logic [31:0] addrT;     // Byte address

    // Byte address of a line, offset bits all zero
    typedef logic [31:0] lineAddrT;

    ////////////////////////////////////////////////
    // Default geometry
    ////////////////////////////////////////////////

    // 64 lines of 8 words give 2 KiB
    localparam int DefNumLines     = 64;
    localparam int DefWordsPerLine = 8;

    // Tag, index and offset widths follow from these two values
    // inside each module, so any power of two works

endpackage

// File: rtl/memBusPkg.sv
package memBusPkg;

    // Word slot in a line with headroom beyond any real line size
    typedef logic [7:0] beatIdxT;

    ////////////////////////////////////////////////
    // Miss handling states
    ////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,           // Hits served, misses accepted
        MISS_FILL,      // Waiting for the critical word
        WAIT_DONE,      // Rest of the fill and the write-back
        LINE_WRITE      // Filled line goes into the array
    } ctrlStateT;

endpackage

// File: rtl/cacheIfs.sv
`timescale 1ns/1ps

// Controller to storage array
interface arrayPortIf import cacheGeomPkg::*; #(
    parameter int NumLines,
    parameter int WordsPerLine
) ();
    localparam int TagW = 32 - $clog2(NumLines) - $clog2(WordsPerLine) - 2;

    addrT                    addr;          // Lookup and write address
    logic                    wordWe;
    wordT                    wdata;
    logic                    lineWe;
    wordT [WordsPerLine-1:0] lineData;
    logic [TagW-1:0]         newTag;
    logic                    newDirty;
    logic                    hit;
    logic                    victimDirty;
    logic [TagW-1:0]         victimTag;
    wordT                    rdata;         // Registered
    wordT [WordsPerLine-1:0] victimLine;

    modport ctrl (output addr, wordWe, wdata, lineWe, lineData, newTag, newDirty,
                  input hit, victimDirty, victimTag, rdata, victimLine);
    modport array (input addr, wordWe, wdata, lineWe, lineData, newTag, newDirty,
                   output hit, victimDirty, victimTag, rdata, victimLine);
endinterface

// Controller to line fill buffer
interface fillBufIf import cacheGeomPkg::*, memBusPkg::*; #(
    parameter int WordsPerLine
) ();
    logic                    start;
    lineAddrT                lineAddr;
    beatIdxT                 critIdx;
    logic                    firstWord;     // Critical word is in
    wordT                    firstData;
    logic                    done;
    wordT [WordsPerLine-1:0] line;

    modport ctrl (output start, lineAddr, critIdx, input firstWord, firstData, done, line);
    modport buffer (input start, lineAddr, critIdx, output firstWord, firstData, done, line);
endinterface

// Controller to line write buffer
interface writeBufIf import cacheGeomPkg::*; #(
    parameter int WordsPerLine
) ();
    logic                    start;
    lineAddrT                victimAddr;
    wordT [WordsPerLine-1:0] victimLine;
    logic                    done;

    modport ctrl (output start, victimAddr, victimLine, input done);
    modport buffer (input start, victimAddr, victimLine, output done);
endinterface

// File: rtl/dCacheCtrl.sv
`timescale 1ns/1ps

module dCacheCtrl import cacheGeomPkg::*, memBusPkg::*; #(
    parameter int NumLines,
    parameter int WordsPerLine
) (
    input  logic     Clk,
    input  logic     rst,
    input  logic     reqValid,
    output logic     reqReady,
    input  logic     reqWrite,
    input  addrT     reqAddr,
    input  wordT     reqWdata,
    output logic     rspValid,
    output wordT     rspData,
    arrayPortIf.ctrl arr,
    fillBufIf.ctrl   fb,
    writeBufIf.ctrl  wb
);
    localparam int IdxW = $clog2(NumLines);
    localparam int OffW = $clog2(WordsPerLine);
    localparam int TagW = 32 - IdxW - OffW - 2;

    ctrlStateT               state;
    logic                    readyQ;
    logic                    hitRspQ;       // Read hit answered next cycle
    logic                    fillBusy;
    logic                    wrBusy;
    addrT                    capAddr;
    logic                    capWrite;
    wordT                    capWdata;
    addrT                    curAddr;
    logic                    accept;
    logic                    missAcc;
    logic                    fillFree;
    logic                    wrFree;
    wordT [WordsPerLine-1:0] mergedLine;

    ////////////////////////////////////////////////
    // Lookup and stall
    ////////////////////////////////////////////////

    assign reqReady = readyQ;
    assign accept   = reqValid && readyQ;
    assign missAcc  = accept && !arr.hit;
    assign curAddr  = (state == IDLE) ? reqAddr : capAddr;

    assign arr.addr   = curAddr;
    assign arr.wordWe = accept && reqWrite && arr.hit;  // Write hit
    assign arr.wdata  = reqWdata;

    // Both buffers start on the accepting edge of a miss
    assign fb.start    = missAcc;
    assign fb.lineAddr = lineAddrT'(curAddr) & ~lineAddrT'(WordsPerLine * 4 - 1);
    assign fb.critIdx  = beatIdxT'(curAddr[2 +: OffW]);

    assign wb.start      = missAcc && arr.victimDirty;
    assign wb.victimAddr = {arr.victimTag, curAddr[OffW + 2 +: IdxW], {(OffW + 2){1'b0}}};
    assign wb.victimLine = arr.victimLine;

    // A finished buffer or one that never ran
    assign fillFree = !fillBusy || fb.done;
    assign wrFree   = !wrBusy || wb.done;

    ////////////////////////////////////////////////
    // Line install with the store merged in
    ////////////////////////////////////////////////

    always_comb begin
        mergedLine = fb.line;
        if (capWrite) begin
            mergedLine[capAddr[2 +: OffW]] = capWdata;
        end
    end

    assign arr.lineWe   = (state == LINE_WRITE);
    assign arr.lineData = mergedLine;
    assign arr.newTag   = capAddr[31 -: TagW];
    assign arr.newDirty = capWrite;                 // Only write misses leave it dirty

    // Critical word of a read miss goes straight out
    assign rspValid = hitRspQ || (fb.firstWord && !capWrite && state == MISS_FILL);
    assign rspData  = hitRspQ ? arr.rdata : fb.firstData;

    ////////////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            state    <= IDLE;
            readyQ   <= 1'b0;
            hitRspQ  <= 1'b0;
            fillBusy <= 1'b0;
            wrBusy   <= 1'b0;
        end else begin
            hitRspQ <= accept && !reqWrite && arr.hit;
            if (fb.done) fillBusy <= 1'b0;
            if (wb.done) wrBusy <= 1'b0;
            case (state)
                IDLE: begin
                    readyQ <= 1'b1;
                    if (missAcc) begin
                        state    <= MISS_FILL;
                        readyQ   <= 1'b0;
                        fillBusy <= 1'b1;
                        wrBusy   <= arr.victimDirty;
                    end
                end
                MISS_FILL: begin
                    if (fb.firstWord) begin
                        state <= (fillFree && wrFree) ? LINE_WRITE : WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    if (fillFree && wrFree) state <= LINE_WRITE;
                end
                LINE_WRITE: begin
                    state  <= IDLE;
                    readyQ <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Missed request held for the whole miss
    always_ff @(posedge Clk) begin
        if (missAcc) begin
            capAddr  <= reqAddr;
            capWrite <= reqWrite;
            capWdata <= reqWdata;
        end
    end

endmodule

// File: rtl/cacheArray.sv
`timescale 1ns/1ps

module cacheArray import cacheGeomPkg::*; #(
    parameter int NumLines,
    parameter int WordsPerLine
) (
    input  logic      Clk,
    input  logic      rst,
    arrayPortIf.array ap
);
    localparam int IdxW = $clog2(NumLines);
    localparam int OffW = $clog2(WordsPerLine);
    localparam int TagW = 32 - IdxW - OffW - 2;

    logic [NumLines-1:0]     validQ;
    logic [NumLines-1:0]     dirtyQ;
    logic [TagW-1:0]         tagMem [NumLines];
    wordT [WordsPerLine-1:0] dataMem [NumLines];
    logic [IdxW-1:0]         idx;
    logic [OffW-1:0]         off;
    logic [TagW-1:0]         tag;

    // Address split
    assign idx = ap.addr[OffW + 2 +: IdxW];
    assign off = ap.addr[2 +: OffW];
    assign tag = ap.addr[31 -: TagW];

    ////////////////////////////////////////////////
    // Tag compare and victim info
    ////////////////////////////////////////////////

    assign ap.hit         = validQ[idx] && (tagMem[idx] == tag);
    assign ap.victimDirty = validQ[idx] && dirtyQ[idx];
    assign ap.victimTag   = tagMem[idx];
    assign ap.victimLine  = dataMem[idx];

    always_ff @(posedge Clk) begin
        if (rst) begin
            validQ <= '0;
        end else if (ap.lineWe) begin
            validQ[idx] <= 1'b1;
        end
    end

    // Line install wins over a word write
    always_ff @(posedge Clk) begin
        if (ap.lineWe) begin
            tagMem[idx]  <= ap.newTag;
            dirtyQ[idx]  <= ap.newDirty;
            dataMem[idx] <= ap.lineData;
        end else if (ap.wordWe) begin
            dataMem[idx][off] <= ap.wdata;
            dirtyQ[idx]       <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        ap.rdata <= dataMem[idx][off];  // Read every cycle
    end

endmodule

// File: rtl/lineFillBuf.sv
`timescale 1ns/1ps

module lineFillBuf import cacheGeomPkg::*, memBusPkg::*; #(
    parameter int WordsPerLine
) (
    input  logic     Clk,
    input  logic     rst,
    fillBufIf.buffer fb,
    output logic     memRdReqValid,
    input  logic     memRdReqReady,
    output addrT     memRdAddr,
    input  logic     memRdValid,
    input  logic     memRdLast,
    input  wordT     memRdData
);
    beatIdxT beatCnt;       // Slot of the next beat
    logic    firstPend;

    always_ff @(posedge Clk) begin
        if (rst) begin
            memRdReqValid <= 1'b0;
            firstPend     <= 1'b0;
            fb.firstWord  <= 1'b0;
            fb.done       <= 1'b0;
            beatCnt       <= '0;
        end else begin
            fb.firstWord <= memRdValid && firstPend;
            fb.done      <= memRdValid && memRdLast;
            if (fb.start) begin
                memRdReqValid <= 1'b1;
                firstPend     <= 1'b1;
                beatCnt       <= fb.critIdx;
            end else if (memRdReqValid && memRdReqReady) begin
                memRdReqValid <= 1'b0;
            end
            if (memRdValid) begin
                firstPend <= 1'b0;
                // Wrap back to slot 0 after the top word
                beatCnt   <= (beatCnt == beatIdxT'(WordsPerLine - 1)) ? '0 : beatCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (fb.start) memRdAddr <= fb.lineAddr | addrT'({fb.critIdx, 2'b00});
        if (memRdValid) fb.line[beatCnt] <= memRdData;
        if (memRdValid && firstPend) fb.firstData <= memRdData;
    end

endmodule

// File: rtl/lineWriteBuf.sv
`timescale 1ns/1ps

module lineWriteBuf import cacheGeomPkg::*, memBusPkg::*; #(
    parameter int WordsPerLine
) (
    input  logic      Clk,
    input  logic      rst,
    writeBufIf.buffer wb,
    output logic      memWrValid,
    input  logic      memWrReady,
    output addrT      memWrAddr,
    output wordT      memWrData,
    output logic      memWrLast
);
    wordT [WordsPerLine-1:0] lineQ;
    beatIdxT                 wordIdx;

    assign memWrData = lineQ[wordIdx];
    assign memWrLast = (wordIdx == beatIdxT'(WordsPerLine - 1));

    always_ff @(posedge Clk) begin
        if (rst) begin
            memWrValid <= 1'b0;
            wordIdx    <= '0;
            wb.done    <= 1'b0;
        end else begin
            wb.done <= 1'b0;
            if (wb.start) begin
                memWrValid <= 1'b1;
                wordIdx    <= '0;
            end else if (memWrValid && memWrReady) begin
                if (memWrLast) begin
                    memWrValid <= 1'b0;
                    wb.done    <= 1'b1;     // Pulse after the last beat
                end else begin
                    wordIdx <= wordIdx + 1'b1;
                end
            end
        end
    end

    // Victim line and address held for all beats
    always_ff @(posedge Clk) begin
        if (wb.start) begin
            lineQ     <= wb.victimLine;
            memWrAddr <= wb.victimAddr;
        end
    end

endmodule

// File: rtl/dCacheTop.sv
`timescale 1ns/1ps

module dCacheTop import cacheGeomPkg::*; #(
    parameter int NumLines     = DefNumLines,
    parameter int WordsPerLine = DefWordsPerLine
) (
    input  logic Clk,
    input  logic rst,
    input  logic reqValid,
    input  logic reqWrite,
    input  addrT reqAddr,
    input  wordT reqWdata,
    output logic reqReady,
    output logic rspValid,
    output wordT rspData,
    output logic memRdReqValid,
    input  logic memRdReqReady,
    output addrT memRdAddr,
    input  logic memRdValid,
    input  logic memRdLast,
    input  wordT memRdData,
    output logic memWrValid,
    input  logic memWrReady,
    output addrT memWrAddr,
    output wordT memWrData,
    output logic memWrLast
);
    arrayPortIf #(.NumLines(NumLines), .WordsPerLine(WordsPerLine)) arrIf ();
    fillBufIf   #(.WordsPerLine(WordsPerLine)) fillIf ();
    writeBufIf  #(.WordsPerLine(WordsPerLine)) wrIf ();

    dCacheCtrl #(.NumLines(NumLines), .WordsPerLine(WordsPerLine)) uCtrl (
        .Clk, .rst, .reqValid, .reqReady, .reqWrite, .reqAddr, .reqWdata,
        .rspValid, .rspData, .arr(arrIf.ctrl), .fb(fillIf.ctrl), .wb(wrIf.ctrl));

    cacheArray #(.NumLines(NumLines), .WordsPerLine(WordsPerLine)) uArray (
        .Clk, .rst, .ap(arrIf.array));

    // Fill and write-back run side by side on separate channels
    lineFillBuf #(.WordsPerLine(WordsPerLine)) uFill (
        .Clk, .rst, .fb(fillIf.buffer), .memRdReqValid, .memRdReqReady, .memRdAddr,
        .memRdValid, .memRdLast, .memRdData);

    lineWriteBuf #(.WordsPerLine(WordsPerLine)) uWrite (
        .Clk, .rst, .wb(wrIf.buffer), .memWrValid, .memWrReady, .memWrAddr,
        .memWrData, .memWrLast);

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic Clk,
    output logic rst
);
    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;      // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge Clk);
        rst <= 1'b0;
    end
endmodule

// File: bench/cacheChecker.sv
`timescale 1ns/1ps

module cacheChecker import cacheGeomPkg::*; #(
    parameter int NumLines     = DefNumLines,
    parameter int WordsPerLine = DefWordsPerLine
) (
    input  logic Clk,
    input  logic rst,
    input  logic reqValid,
    input  logic reqReady,
    input  logic reqWrite,
    input  addrT reqAddr,
    input  wordT reqWdata,
    input  logic rspValid,
    input  wordT rspData,
    input  logic memRdReqValid,
    input  logic memRdReqReady,
    input  addrT memRdAddr,
    input  logic memWrValid,
    input  logic memWrReady,
    input  addrT memWrAddr,
    input  wordT memWrData,
    input  logic memWrLast,
    output int   errCount,
    output logic idle
);
    localparam int LineBytes = WordsPerLine * 4;

    wordT refImg [addrT];           // CPU-visible values
    addrT resLine [NumLines];       // Line held at each index
    logic resValid [NumLines];
    logic resDirty [NumLines];
    wordT rspQ [$];
    addrT rdReqQ [$];
    addrT wbLine;
    int   wbLeft;                   // Write-back beats still owed
    logic hitDue;
    logic readyDue;
    logic expReady;

    initial errCount = 0;

    function automatic wordT refWord(addrT a);
        return refImg.exists(a) ? refImg[a] : (a ^ 32'hA5A5_0000);
    endfunction

    task automatic compare(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic complain(string what);
        $display("Failure at %0t: %s", $time, what);
        errCount++;
    endtask

    //////////////////////////////////////////////////
    // Responses and memory traffic
    //////////////////////////////////////////////////

    always @(posedge Clk) begin : watch
        int   idx;
        addrT lineA;
        logic hit;
        if (rst) begin
            if (reqReady === 1'b1) complain("reqReady is high during reset");
            for (int i = 0; i < NumLines; i++) resValid[i] = 1'b0;
            hitDue   = 1'b0;
            readyDue = 1'b0;
            wbLeft   = 0;
        end else begin
            if (hitDue && !rspValid) complain("no response in the cycle after a read hit");
            hitDue = 1'b0;
            if (readyDue) compare("reqReady", reqReady, expReady);
            readyDue = 1'b0;
            if (rspValid) begin
                if (rspQ.size() == 0) complain("response without a pending read");
                else compare("rspData", rspData, rspQ.pop_front());
            end
            // Critical word address goes out first
            if (memRdReqValid && memRdReqReady) begin
                if (rdReqQ.size() == 0) complain("read request without a miss");
                else compare("memRdAddr", memRdAddr, rdReqQ.pop_front());
            end
            if (memWrValid && memWrReady) begin
                if (wbLeft == 0) begin
                    complain("write beat without a dirty eviction");
                end else begin
                    compare("memWrAddr", memWrAddr, wbLine);
                    compare("memWrData", memWrData,
                            refWord(wbLine + 4 * (WordsPerLine - wbLeft)));
                    compare("memWrLast", memWrLast, wbLeft == 1);
                    wbLeft--;
                end
            end

            //////////////////////////////////////////////////
            // Accepted request
            //////////////////////////////////////////////////
            if (reqValid && reqReady) begin
                idx   = (reqAddr / LineBytes) % NumLines;
                lineA = reqAddr & ~addrT'(LineBytes - 1);
                hit   = resValid[idx] && (resLine[idx] == lineA);
                if (!hit) begin
                    rdReqQ.push_back(reqAddr & ~addrT'(3));
                    if (resValid[idx] && resDirty[idx]) begin
                        if (wbLeft != 0) complain("write-back started before the last one ended");
                        wbLine = resLine[idx];
                        wbLeft = WordsPerLine;
                    end
                    resLine[idx]  = lineA;
                    resValid[idx] = 1'b1;
                    resDirty[idx] = 1'b0;
                end
                if (reqWrite) begin
                    refImg[reqAddr & ~addrT'(3)] = reqWdata;
                    resDirty[idx] = 1'b1;
                end else begin
                    rspQ.push_back(refWord(reqAddr & ~addrT'(3)));
                    hitDue = hit;
                end
                readyDue = 1'b1;
                expReady = hit;     // A miss drops reqReady next cycle
            end
        end
        idle <= (rspQ.size() == 0) && (rdReqQ.size() == 0) && (wbLeft == 0);
    end

endmodule

// File: bench/dCacheTb.sv
`timescale 1ns/1ps

module dCacheTb import cacheGeomPkg::*; ();
    localparam int WordsPerLine = DefWordsPerLine;
    localparam int ReqTimeout   = 400;
    localparam int NumStim      = 16;

    typedef struct packed {
        logic wr;
        addrT addr;
        wordT data;
    } stimT;

    // Write flag, byte address and store data per entry
    // Index bits are [10:5]
    localparam stimT StimTab [NumStim] = '{
        '{1'b0, 32'h0000_1014, 32'h0},          // Cold miss with word 5 first
        '{1'b0, 32'h0000_1000, 32'h0},
        '{1'b1, 32'h0000_1008, 32'h1111_0001},  // Write hit turns the line dirty
        '{1'b0, 32'h0000_1008, 32'h0},
        '{1'b1, 32'h0000_2044, 32'h2222_0002},  // Write miss allocates
        '{1'b0, 32'h0000_2044, 32'h0},
        '{1'b0, 32'h0000_2040, 32'h0},          // Neighbours of the store
        '{1'b0, 32'h0000_205C, 32'h0},
        '{1'b0, 32'h0000_1814, 32'h0},          // Dirty victim 0x1000
        '{1'b0, 32'h0000_1008, 32'h0},          // Clean victim 0x1800
        '{1'b0, 32'h0000_2844, 32'h0},
        '{1'b0, 32'h0000_2044, 32'h0},
        '{1'b1, 32'h0000_3000, 32'h3333_0003},
        '{1'b1, 32'h0000_3004, 32'h3333_0004},
        '{1'b0, 32'h0000_381C, 32'h0},
        '{1'b0, 32'h0000_3004, 32'h0}
    };

    logic Clk, rst;
    logic reqValid, reqReady, reqWrite, rspValid;
    addrT reqAddr, memRdAddr, memWrAddr;
    wordT reqWdata, rspData, memRdData, memWrData;
    logic memRdReqValid, memRdReqReady, memRdValid, memRdLast;
    logic memWrValid, memWrReady, memWrLast;
    wordT memImg [addrT];           // Sparse memory behind the cache
    int   wrBeat;
    logic rdStall;
    int   errCount;
    int   timeouts;
    logic chkIdle;

    clockGen uClk (.Clk, .rst);
    dCacheTop DUT (.*);
    cacheChecker uCheck (.*, .idle(chkIdle));

    function automatic wordT readWord(addrT a);
        return memImg.exists(a) ? memImg[a] : (a ^ 32'hA5A5_0000);
    endfunction

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    initial begin : randomSource
        void'($urandom(67606));
        memRdReqReady = 1'b0;
        memWrReady    = 1'b0;
        rdStall       = 1'b0;
        forever begin
            @(posedge Clk);
            memRdReqReady <= ($urandom % 4) != 0;
            memWrReady    <= ($urandom % 3) != 0;
            rdStall       <= ($urandom % 3) == 0;
        end
    end

    // Beats wrap from the critical word
    initial begin : readChannel
        addrT lineBase;
        int   crit;
        int   stalls;
        memRdValid = 1'b0;
        memRdLast  = 1'b0;
        memRdData  = '0;
        forever begin
            @(posedge Clk);
            memRdValid <= 1'b0;
            memRdLast  <= 1'b0;
            if (!rst && memRdReqValid && memRdReqReady) begin
                lineBase = memRdAddr & ~addrT'(WordsPerLine * 4 - 1);
                crit     = (memRdAddr / 4) % WordsPerLine;
                for (int b = 0; b < WordsPerLine; b++) begin
                    @(posedge Clk);
                    stalls = 0;
                    while (rdStall && stalls < 6) begin
                        memRdValid <= 1'b0;
                        memRdLast  <= 1'b0;
                        stalls++;
                        @(posedge Clk);
                    end
                    memRdValid <= 1'b1;
                    memRdData  <= readWord(lineBase + 4 * ((crit + b) % WordsPerLine));
                    memRdLast  <= (b == WordsPerLine - 1);
                end
            end
        end
    end

    always @(posedge Clk) begin
        if (rst) begin
            wrBeat = 0;
        end else if (memWrValid && memWrReady) begin
            memImg[memWrAddr + 4 * wrBeat] = memWrData;
            wrBeat = memWrLast ? 0 : wrBeat + 1;
        end
    end

    //////////////////////////////////////////////////
    // CPU side
    //////////////////////////////////////////////////

    task automatic awaitReady(string what);
        int cnt;
        cnt = 0;
        do begin
            @(posedge Clk);
            cnt++;
        end while ((rst || !reqReady) && cnt < ReqTimeout);
        if (rst || !reqReady) begin
            timeouts++;
            $display("Timeout waiting for %s, controller in %s", what, DUT.uCtrl.state.name());
        end
    endtask

    task automatic sendReq(stimT s);
        reqValid <= 1'b1;
        reqWrite <= s.wr;
        reqAddr  <= s.addr;
        reqWdata <= s.data;
        awaitReady("request acceptance");
    endtask

    task automatic awaitIdle();
        int cnt;
        cnt = 0;
        do begin
            @(posedge Clk);
            cnt++;
        end while (!(chkIdle && reqReady) && cnt < ReqTimeout);
        if (!(chkIdle && reqReady)) begin
            timeouts++;
            $display("Timeout waiting for outstanding responses and write-backs");
        end
    endtask

    initial begin : stimulus
        timeouts = 0;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr  = '0;
        reqWdata = '0;
        awaitReady("reqReady after reset");
        for (int i = 0; i < NumStim && timeouts == 0; i++) begin
            sendReq(StimTab[i]);
        end
        reqValid <= 1'b0;
        if (timeouts == 0) awaitIdle();
        @(negedge Clk);
        $display("Run summary: %0d check errors, %0d timeouts", errCount, timeouts);
        if (errCount == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/cacheGeomPkg.sv
rtl/memBusPkg.sv
rtl/cacheIfs.sv
rtl/dCacheCtrl.sv
rtl/cacheArray.sv
rtl/lineFillBuf.sv
rtl/lineWriteBuf.sv
rtl/dCacheTop.sv
bench/clockGen.sv
bench/cacheChecker.sv
bench/dCacheTb.sv
